//--- hdl/axil_pkg.sv
package axil_pkg;

    ////////////////////////////////////////
    // bus widths
    ////////////////////////////////////////

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    // one strobe bit per byte lane
    localparam int STRB_W = DATA_W / 8;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [STRB_W-1:0] strb_t;

    // response codes as on the bus
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } resp_e;

    ////////////////////////////////////////
    // channel bundles
    ////////////////////////////////////////

    // everything the master drives
    typedef struct packed {
        logic  awvalid;
        addr_t awaddr;
        logic  wvalid;
        data_t wdata;
        strb_t wstrb;
        logic  bready;
        logic  arvalid;
        addr_t araddr;
        logic  rready;
    } axil_req_t;

    // everything the slave drives
    typedef struct packed {
        logic  awready;
        logic  wready;
        logic  bvalid;
        resp_e bresp;
        logic  arready;
        logic  rvalid;
        data_t rdata;
        resp_e rresp;
    } axil_rsp_t;

endpackage

//--- hdl/mem_map_pkg.sv
package mem_map_pkg;

    ////////////////////////////////////////
    // address map
    ////////////////////////////////////////

    // region select lives in the top nibble
    localparam int REGION_LSB = 28;
    localparam int REGION_W   = 4;
    // byte offset bits inside a 32-bit word
    localparam int WORD_OFS_W = 2;

    // anything below REG_TEXT is the old ddr main memory
    typedef enum logic [REGION_W-1:0] {
        REG_TEXT   = 4'hc,
        REG_TIMER  = 4'hd,
        REG_KBD    = 4'he,
        REG_LOADER = 4'hf
    } region_e;

    ////////////////////////////////////////
    // text memory
    ////////////////////////////////////////

    localparam int CHAR_W      = 8;
    // wide enough for the largest text depth
    localparam int TEXT_ADDR_W = 16;

    typedef logic [CHAR_W-1:0]      char_t;
    typedef logic [TEXT_ADDR_W-1:0] text_addr_t;

    // one queued character write
    typedef struct packed {
        text_addr_t addr;
        char_t      char;
    } text_wr_t;

endpackage

//--- hdl/axil_data_port.sv
`timescale 1ns/1ps

module axil_data_port #(
    parameter int TEXT_DEPTH   = 4096,
    parameter int LOADER_WORDS = 1024
) (
    input  logic                            text_mem_clk,
    input  logic                            reset,
    input  axil_pkg::axil_req_t             axil_req,
    output axil_pkg::axil_rsp_t             axil_rsp,
    input  logic                            fifo_full,
    output logic                            fifo_push,
    output mem_map_pkg::text_wr_t           fifo_data,
    output logic                            ld_wen,
    output axil_pkg::strb_t                 ld_wstrb,
    output logic [$clog2(LOADER_WORDS)-1:0] ld_addr,
    output axil_pkg::data_t                 ld_wdata,
    input  axil_pkg::data_t                 ld_rdata
);

    localparam int LD_AW       = $clog2(LOADER_WORDS);
    localparam int WORD_OFS_W  = mem_map_pkg::WORD_OFS_W;
    // word bits of a text address, lane index fills the rest
    localparam int TEXT_WORD_W = $clog2(TEXT_DEPTH) - WORD_OFS_W;
    localparam int LANE_W      = $clog2(axil_pkg::STRB_W);

    typedef enum logic {
        WR_IDLE,
        WR_RESP
    } wr_state_e;

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_RAM,
        RD_DATA,
        RD_RESP
    } rd_state_e;

    wr_state_e             wr_state;
    rd_state_e             rd_state;

    mem_map_pkg::region_e  wr_region;
    logic                  wr_is_text;
    logic                  wr_is_loader;
    axil_pkg::resp_e       wr_resp;
    logic                  strb_onehot;
    logic [LANE_W-1:0]     lane;
    mem_map_pkg::char_t    lane_char;
    logic                  wr_accept;
    axil_pkg::resp_e       bresp_q;

    logic                  ar_accept;
    mem_map_pkg::region_e  rd_region_q;
    logic [LD_AW-1:0]      rd_word_q;
    axil_pkg::data_t       rd_sel_data;
    axil_pkg::resp_e       rd_sel_resp;
    axil_pkg::data_t       rdata_q;
    axil_pkg::resp_e       rresp_q;

    ////////////////////////////////////////
    // write decode
    ////////////////////////////////////////

    assign wr_region   = mem_map_pkg::region_e'(
        axil_req.awaddr[mem_map_pkg::REGION_LSB +: mem_map_pkg::REGION_W]);
    assign strb_onehot = $onehot(axil_req.wstrb);

    always_comb begin
        wr_is_text   = 1'b0;
        wr_is_loader = 1'b0;
        wr_resp      = axil_pkg::OKAY;
        case (wr_region)
            mem_map_pkg::REG_TEXT: begin
                wr_is_text = 1'b1;
                // text takes exactly one byte per write
                if (!strb_onehot) begin
                    wr_resp = axil_pkg::SLVERR;
                end
            end
            mem_map_pkg::REG_TIMER, mem_map_pkg::REG_KBD: begin
                // writes dropped
                wr_resp = axil_pkg::OKAY;
            end
            mem_map_pkg::REG_LOADER: begin
                wr_is_loader = 1'b1;
            end
            default: begin
                // old main memory window
                wr_resp = axil_pkg::DECERR;
            end
        endcase
    end

    // strobe bit i picks byte lane i
    always_comb begin
        lane      = '0;
        lane_char = '0;
        for (int i = 0; i < axil_pkg::STRB_W; i++) begin
            if (axil_req.wstrb[i]) begin
                lane      = LANE_W'(i);
                lane_char = axil_req.wdata[8*i +: 8];
            end
        end
    end

    // aw and w together, no response pending
    // full buffer holds off text, a busy loader port holds off loader
    assign wr_accept = axil_req.awvalid && axil_req.wvalid && (wr_state == WR_IDLE)
                       && !(wr_is_text && fifo_full)
                       && !(wr_is_loader && (rd_state == RD_RAM));

    assign fifo_push      = wr_accept && wr_is_text && strb_onehot;
    // wrapped word offset times four plus lane
    assign fifo_data.addr = mem_map_pkg::text_addr_t'(
        {axil_req.awaddr[WORD_OFS_W +: TEXT_WORD_W], lane});
    assign fifo_data.char = lane_char;

    // loader data port shared by writes and read stage one
    assign ld_wen   = wr_accept && wr_is_loader;
    assign ld_wstrb = axil_req.wstrb;
    assign ld_wdata = axil_req.wdata;
    assign ld_addr  = ld_wen ? axil_req.awaddr[WORD_OFS_W +: LD_AW] : rd_word_q;

    always_ff @(posedge text_mem_clk) begin
        if (reset) begin
            wr_state <= WR_IDLE;
        end else begin
            case (wr_state)
                WR_IDLE: if (wr_accept) wr_state <= WR_RESP;
                WR_RESP: if (axil_req.bready) wr_state <= WR_IDLE;
            endcase
        end
    end

    always_ff @(posedge text_mem_clk) begin
        if (wr_accept) begin
            bresp_q <= wr_resp;
        end
    end

    ////////////////////////////////////////
    // read pipeline
    ////////////////////////////////////////

    // one read at a time
    assign ar_accept = axil_req.arvalid && (rd_state == RD_IDLE);

    always_ff @(posedge text_mem_clk) begin
        if (ar_accept) begin
            rd_region_q <= mem_map_pkg::region_e'(
                axil_req.araddr[mem_map_pkg::REGION_LSB +: mem_map_pkg::REGION_W]);
            rd_word_q   <= axil_req.araddr[WORD_OFS_W +: LD_AW];
        end
    end

    // ram output valid in RD_DATA
    always_comb begin
        rd_sel_data = '0;
        rd_sel_resp = axil_pkg::OKAY;
        case (rd_region_q)
            mem_map_pkg::REG_LOADER: begin
                rd_sel_data = ld_rdata;
            end
            mem_map_pkg::REG_TEXT, mem_map_pkg::REG_TIMER, mem_map_pkg::REG_KBD: begin
                rd_sel_data = '0;
            end
            default: begin
                rd_sel_resp = axil_pkg::DECERR;
            end
        endcase
    end

    always_ff @(posedge text_mem_clk) begin
        if (reset) begin
            rd_state <= RD_IDLE;
        end else begin
            case (rd_state)
                RD_IDLE: if (ar_accept) rd_state <= RD_RAM;
                // loader ram samples rd_word_q here
                RD_RAM:  rd_state <= RD_DATA;
                RD_DATA: rd_state <= RD_RESP;
                RD_RESP: if (axil_req.rready) rd_state <= RD_IDLE;
            endcase
        end
    end

    always_ff @(posedge text_mem_clk) begin
        if (rd_state == RD_DATA) begin
            rdata_q <= rd_sel_data;
            rresp_q <= rd_sel_resp;
        end
    end

    ////////////////////////////////////////
    // response channels
    ////////////////////////////////////////

    always_comb begin
        axil_rsp.awready = wr_accept;
        axil_rsp.wready  = wr_accept;
        axil_rsp.bvalid  = (wr_state == WR_RESP);
        axil_rsp.bresp   = bresp_q;
        axil_rsp.arready = ar_accept;
        axil_rsp.rvalid  = (rd_state == RD_RESP);
        axil_rsp.rdata   = rdata_q;
        axil_rsp.rresp   = rresp_q;
    end

    // responses stay put until taken
    a_bvalid_hold: assert property (@(posedge text_mem_clk) disable iff (reset)
        axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid && $stable(axil_rsp.bresp));

    a_rvalid_hold: assert property (@(posedge text_mem_clk) disable iff (reset)
        axil_rsp.rvalid && !axil_req.rready |=>
            axil_rsp.rvalid && $stable(axil_rsp.rdata) && $stable(axil_rsp.rresp));

    // rvalid rises two cycles after the address handshake
    // so it is first sampled high three edges after ar_accept
    a_rd_latency: assert property (@(posedge text_mem_clk) disable iff (reset)
        axil_rsp.rvalid && !$past(axil_rsp.rvalid) |-> $past(ar_accept, 3));

endmodule

//--- hdl/text_write_fifo.sv
`timescale 1ns/1ps

module text_write_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                  text_mem_clk,
    input  logic                  reset,
    input  logic                  push,
    input  mem_map_pkg::text_wr_t push_data,
    input  logic                  pop,
    output logic                  full,
    output logic                  valid,
    output mem_map_pkg::text_wr_t pop_data
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    mem_map_pkg::text_wr_t mem [FIFO_DEPTH];
    logic [PTR_W-1:0]      wr_ptr;
    logic [PTR_W-1:0]      rd_ptr;
    logic [CNT_W-1:0]      count;

    // wrap at depth, need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        ptr_next = (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full     = (count == CNT_W'(FIFO_DEPTH));
    assign valid    = (count != '0);
    // head entry shown without a read cycle
    assign pop_data = mem[rd_ptr];

    always_ff @(posedge text_mem_clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge text_mem_clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= ptr_next(wr_ptr);
            if (pop) rd_ptr <= ptr_next(rd_ptr);
            // simultaneous push and pop keeps the count
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_no_overflow: assert property (@(posedge text_mem_clk) disable iff (reset)
        push |-> !full);

    a_no_underflow: assert property (@(posedge text_mem_clk) disable iff (reset)
        pop |-> valid);

endmodule

//--- hdl/text_mem.sv
`timescale 1ns/1ps

module text_mem #(
    parameter int TEXT_DEPTH = 4096
) (
    input  logic                    text_mem_clk,
    input  logic                    reset,
    input  logic                    wr_valid,
    input  mem_map_pkg::text_wr_t   wr_data,
    output logic                    wr_pop,
    input  mem_map_pkg::text_addr_t char_addr,
    output mem_map_pkg::char_t      char_data
);

    localparam int ADDR_W = $clog2(TEXT_DEPTH);

    mem_map_pkg::char_t ram [TEXT_DEPTH];

    ////////////////////////////////////////
    // write side
    ////////////////////////////////////////

    // one character per cycle so the head is always taken
    assign wr_pop = wr_valid;

    always_ff @(posedge text_mem_clk) begin
        if (wr_valid) begin
            ram[wr_data.addr[ADDR_W-1:0]] <= wr_data.char;
        end
    end

    ////////////////////////////////////////
    // display side
    ////////////////////////////////////////

    // registered read for the scan generator
    always_ff @(posedge text_mem_clk) begin
        char_data <= ram[char_addr[ADDR_W-1:0]];
    end

    // producer wraps addresses so nothing lands past the end
    a_addr_in_range: assert property (@(posedge text_mem_clk) disable iff (reset)
        wr_valid |-> (32'(wr_data.addr) < TEXT_DEPTH));

endmodule

//--- hdl/loader_mem.sv
`timescale 1ns/1ps

module loader_mem #(
    parameter int LOADER_WORDS = 1024
) (
    input  logic                            text_mem_clk,
    input  logic                            d_wen,
    input  axil_pkg::strb_t                 d_wstrb,
    input  logic [$clog2(LOADER_WORDS)-1:0] d_addr,
    input  axil_pkg::data_t                 d_wdata,
    output axil_pkg::data_t                 d_rdata,
    input  logic [$clog2(LOADER_WORDS)-1:0] i_addr,
    output axil_pkg::data_t                 i_data
);

    axil_pkg::data_t ram [LOADER_WORDS];

    ////////////////////////////////////////
    // data port
    ////////////////////////////////////////

    // per-byte enables from the strobe
    always_ff @(posedge text_mem_clk) begin
        if (d_wen) begin
            for (int b = 0; b < axil_pkg::STRB_W; b++) begin
                if (d_wstrb[b]) begin
                    ram[d_addr][8*b +: 8] <= d_wdata[8*b +: 8];
                end
            end
        end
    end

    // read before write on a shared address
    always_ff @(posedge text_mem_clk) begin
        d_rdata <= ram[d_addr];
    end

    ////////////////////////////////////////
    // instruction port
    ////////////////////////////////////////

    // fetch only
    always_ff @(posedge text_mem_clk) begin
        i_data <= ram[i_addr];
    end

endmodule

//--- hdl/cpu_mem_interface.sv
`timescale 1ns/1ps

module cpu_mem_interface #(
    parameter int TEXT_DEPTH   = 4096,
    parameter int LOADER_WORDS = 1024,
    parameter int FIFO_DEPTH   = 4
) (
    input  logic                            text_mem_clk,
    input  logic                            reset,
    input  axil_pkg::axil_req_t             axil_req,
    output axil_pkg::axil_rsp_t             axil_rsp,
    input  mem_map_pkg::text_addr_t         char_addr,
    output mem_map_pkg::char_t              char_data,
    input  logic [$clog2(LOADER_WORDS)-1:0] instr_addr,
    output axil_pkg::data_t                 instr_data
);

    localparam int LD_AW = $clog2(LOADER_WORDS);

    // producer to buffer
    logic                  fifo_push;
    logic                  fifo_full;
    mem_map_pkg::text_wr_t fifo_data;

    // buffer to consumer
    logic                  fifo_valid;
    logic                  fifo_pop;
    mem_map_pkg::text_wr_t fifo_head;

    // loader data port
    logic                  ld_wen;
    axil_pkg::strb_t       ld_wstrb;
    logic [LD_AW-1:0]      ld_addr;
    axil_pkg::data_t       ld_wdata;
    axil_pkg::data_t       ld_rdata;

    ////////////////////////////////////////
    // bus side
    ////////////////////////////////////////

    axil_data_port #(
        .TEXT_DEPTH   (TEXT_DEPTH),
        .LOADER_WORDS (LOADER_WORDS)
    ) i_axil_data_port (
        .text_mem_clk (text_mem_clk),
        .reset        (reset),
        .axil_req     (axil_req),
        .axil_rsp     (axil_rsp),
        .fifo_full    (fifo_full),
        .fifo_push    (fifo_push),
        .fifo_data    (fifo_data),
        .ld_wen       (ld_wen),
        .ld_wstrb     (ld_wstrb),
        .ld_addr      (ld_addr),
        .ld_wdata     (ld_wdata),
        .ld_rdata     (ld_rdata)
    );

    ////////////////////////////////////////
    // text path
    ////////////////////////////////////////

    text_write_fifo #(
        .FIFO_DEPTH   (FIFO_DEPTH)
    ) i_text_write_fifo (
        .text_mem_clk (text_mem_clk),
        .reset        (reset),
        .push         (fifo_push),
        .push_data    (fifo_data),
        .pop          (fifo_pop),
        .full         (fifo_full),
        .valid        (fifo_valid),
        .pop_data     (fifo_head)
    );

    text_mem #(
        .TEXT_DEPTH   (TEXT_DEPTH)
    ) i_text_mem (
        .text_mem_clk (text_mem_clk),
        .reset        (reset),
        .wr_valid     (fifo_valid),
        .wr_data      (fifo_head),
        .wr_pop       (fifo_pop),
        .char_addr    (char_addr),
        .char_data    (char_data)
    );

    ////////////////////////////////////////
    // loader memory
    ////////////////////////////////////////

    loader_mem #(
        .LOADER_WORDS (LOADER_WORDS)
    ) i_loader_mem (
        .text_mem_clk (text_mem_clk),
        .d_wen        (ld_wen),
        .d_wstrb      (ld_wstrb),
        .d_addr       (ld_addr),
        .d_wdata      (ld_wdata),
        .d_rdata      (ld_rdata),
        .i_addr       (instr_addr),
        .i_data       (instr_data)
    );

endmodule

//--- sim/tb_cpu_mem_interface.sv
`timescale 1ns/1ps

module tb_cpu_mem_interface;

    localparam int TEXT_DEPTH   = 4096;
    localparam int LOADER_WORDS = 1024;
    localparam int FIFO_DEPTH   = 4;
    // cycles any single wait may take
    localparam int TIMEOUT      = 64;
    localparam int BURST_LEN    = 16;

    typedef enum {
        OP_WRITE,
        OP_READ,
        OP_TEXT,
        OP_INSTR
    } op_e;

    typedef struct {
        string           name;
        op_e             op;
        axil_pkg::addr_t addr;
        axil_pkg::data_t data;
        axil_pkg::strb_t strb;
        axil_pkg::data_t exp_data;
        axil_pkg::resp_e exp_resp;
    } row_t;

    logic                              text_mem_clk = 1'b0;
    logic                              reset;
    axil_pkg::axil_req_t               axil_req;
    axil_pkg::axil_rsp_t               axil_rsp;
    mem_map_pkg::text_addr_t           char_addr;
    mem_map_pkg::char_t                char_data;
    logic [$clog2(LOADER_WORDS)-1:0]   instr_addr;
    axil_pkg::data_t                   instr_data;

    row_t                rows [$];
    axil_pkg::data_t     ld_model [LOADER_WORDS];
    mem_map_pkg::char_t  text_model [TEXT_DEPTH];
    logic [31:0]         rng_state = 32'hfaea_3dbc;

    // 100 ns period
    always #50 text_mem_clk = ~text_mem_clk;

    cpu_mem_interface #(
        .TEXT_DEPTH   (TEXT_DEPTH),
        .LOADER_WORDS (LOADER_WORDS),
        .FIFO_DEPTH   (FIFO_DEPTH)
    ) i_cpu_mem_interface (
        .text_mem_clk (text_mem_clk),
        .reset        (reset),
        .axil_req     (axil_req),
        .axil_rsp     (axil_rsp),
        .char_addr    (char_addr),
        .char_data    (char_data),
        .instr_addr   (instr_addr),
        .instr_data   (instr_data)
    );

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////

    function automatic logic [31:0] xorshift();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // word offset wrapped to the text depth, then lane
    function automatic int text_index(input axil_pkg::addr_t addr, input int lane);
        return int'((addr >> 2) % (TEXT_DEPTH / 4)) * 4 + lane;
    endfunction

    function automatic int lane_of(input axil_pkg::strb_t strb);
        int lane;
        lane = 0;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) begin
                lane = i;
            end
        end
        return lane;
    endfunction

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("** FAIL **");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic compare_value(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
        if (act !== exp) begin
            fail_run($sformatf("ERR %s expected 0x%08h actual 0x%08h", name, exp, act));
        end
    endtask

    ////////////////////////////////////////
    // bus tasks
    ////////////////////////////////////////

    task automatic write_word(input axil_pkg::addr_t addr, input axil_pkg::data_t data,
                              input axil_pkg::strb_t strb, output axil_pkg::resp_e resp);
        int waited;
        int stall;
        @(posedge text_mem_clk);
        #1;
        axil_req.awvalid = 1'b1;
        axil_req.awaddr  = addr;
        axil_req.wvalid  = 1'b1;
        axil_req.wdata   = data;
        axil_req.wstrb   = strb;
        // both readies come together
        waited = 0;
        @(negedge text_mem_clk);
        while (!(axil_rsp.awready && axil_rsp.wready)) begin
            waited++;
            if (waited > TIMEOUT) begin
                fail_run($sformatf("write to 0x%08h was never accepted", addr));
            end
            @(negedge text_mem_clk);
        end
        @(posedge text_mem_clk);
        #1;
        axil_req.awvalid = 1'b0;
        axil_req.wvalid  = 1'b0;
        stall = int'(xorshift() & 32'h3);
        waited = 0;
        @(negedge text_mem_clk);
        while (!axil_rsp.bvalid) begin
            waited++;
            if (waited > TIMEOUT) begin
                fail_run($sformatf("no write response for 0x%08h", addr));
            end
            @(negedge text_mem_clk);
        end
        compare_value("write response latency", 0, waited);
        // bready held low, response must stay
        repeat (stall) begin
            @(negedge text_mem_clk);
            if (!axil_rsp.bvalid) begin
                fail_run("bvalid dropped while bready was low");
            end
        end
        resp = axil_rsp.bresp;
        @(posedge text_mem_clk);
        #1;
        axil_req.bready = 1'b1;
        @(posedge text_mem_clk);
        #1;
        axil_req.bready = 1'b0;
    endtask

    task automatic read_word(input axil_pkg::addr_t addr, output axil_pkg::data_t data,
                             output axil_pkg::resp_e resp);
        int waited;
        int stall;
        @(posedge text_mem_clk);
        #1;
        axil_req.arvalid = 1'b1;
        axil_req.araddr  = addr;
        waited = 0;
        @(negedge text_mem_clk);
        while (!axil_rsp.arready) begin
            waited++;
            if (waited > TIMEOUT) begin
                fail_run($sformatf("read of 0x%08h was never accepted", addr));
            end
            @(negedge text_mem_clk);
        end
        @(posedge text_mem_clk);
        #1;
        axil_req.arvalid = 1'b0;
        stall = int'(xorshift() & 32'h3);
        waited = 0;
        @(negedge text_mem_clk);
        while (!axil_rsp.rvalid) begin
            waited++;
            if (waited > TIMEOUT) begin
                fail_run($sformatf("no read data for 0x%08h", addr));
            end
            @(negedge text_mem_clk);
        end
        // two cycles from address handshake to rvalid
        compare_value("read latency", 2, waited);
        repeat (stall) begin
            @(negedge text_mem_clk);
            if (!axil_rsp.rvalid) begin
                fail_run("rvalid dropped while rready was low");
            end
        end
        data = axil_rsp.rdata;
        resp = axil_rsp.rresp;
        @(posedge text_mem_clk);
        #1;
        axil_req.rready = 1'b1;
        @(posedge text_mem_clk);
        #1;
        axil_req.rready = 1'b0;
    endtask

    // consumer drains at its own pace, so poll
    task automatic poll_char(input string name, input int idx, input mem_map_pkg::char_t exp);
        int waited;
        @(posedge text_mem_clk);
        #1;
        char_addr = mem_map_pkg::text_addr_t'(idx);
        @(posedge text_mem_clk);
        waited = 0;
        @(negedge text_mem_clk);
        while ((char_data !== exp) && (waited < TIMEOUT)) begin
            waited++;
            @(negedge text_mem_clk);
        end
        compare_value(name, 32'(exp), 32'(char_data));
    endtask

    // one cycle fetch latency
    task automatic fetch_instr(input string name, input int word);
        @(posedge text_mem_clk);
        #1;
        instr_addr = word[$clog2(LOADER_WORDS)-1:0];
        @(posedge text_mem_clk);
        @(negedge text_mem_clk);
        compare_value(name, ld_model[word], instr_data);
    endtask

    ////////////////////////////////////////
    // stimulus table
    ////////////////////////////////////////

    task automatic add_row(input string name, input op_e op, input axil_pkg::addr_t addr,
                           input axil_pkg::data_t data, input axil_pkg::strb_t strb,
                           input axil_pkg::data_t exp_data, input axil_pkg::resp_e exp_resp);
        row_t row;
        row.name     = name;
        row.op       = op;
        row.addr     = addr;
        row.data     = data;
        row.strb     = strb;
        row.exp_data = exp_data;
        row.exp_resp = exp_resp;
        rows.push_back(row);
    endtask

    task automatic build_table();
        // loader, full then partial strobes, last one wraps to word 7
        add_row("ld w0 full", OP_WRITE, 32'hf000_0000, 32'h1122_3344, 4'hf, '0, axil_pkg::OKAY);
        add_row("ld w5 full", OP_WRITE, 32'hf000_0014, 32'hdead_beef, 4'hf, '0, axil_pkg::OKAY);
        add_row("ld w0 low", OP_WRITE, 32'hf000_0000, 32'haaaa_5566, 4'h3, '0, axil_pkg::OKAY);
        add_row("ld w5 byte2", OP_WRITE, 32'hf000_0014, 32'h0077_0000, 4'h4, '0, axil_pkg::OKAY);
        add_row("ld w7 wrap", OP_WRITE, 32'hf000_101c, 32'h0bad_f00d, 4'hf, '0, axil_pkg::OKAY);
        add_row("ld rd w0", OP_READ, 32'hf000_0000, '0, '0, '0, axil_pkg::OKAY);
        add_row("ld rd w5", OP_READ, 32'hf000_0014, '0, '0, '0, axil_pkg::OKAY);
        add_row("ld rd w7", OP_READ, 32'hf000_001c, '0, '0, '0, axil_pkg::OKAY);
        // fetch side sees the same words
        add_row("instr w0", OP_INSTR, 32'd0, '0, '0, '0, axil_pkg::OKAY);
        add_row("instr w5", OP_INSTR, 32'd5, '0, '0, '0, axil_pkg::OKAY);
        add_row("instr w7", OP_INSTR, 32'd7, '0, '0, '0, axil_pkg::OKAY);
        // one character per lane
        add_row("text lane0", OP_WRITE, 32'hc000_0010, 32'h0000_0041, 4'h1, '0, axil_pkg::OKAY);
        add_row("text lane1", OP_WRITE, 32'hc000_0010, 32'h0000_4200, 4'h2, '0, axil_pkg::OKAY);
        add_row("text lane2", OP_WRITE, 32'hc000_0010, 32'h0043_0000, 4'h4, '0, axil_pkg::OKAY);
        add_row("text lane3", OP_WRITE, 32'hc000_0010, 32'h4400_0000, 4'h8, '0, axil_pkg::OKAY);
        add_row("text wrap", OP_WRITE, 32'hc000_1008, 32'h0000_0045, 4'h1, '0, axil_pkg::OKAY);
        add_row("text rd zero", OP_READ, 32'hc000_0010, '0, '0, 32'h0, axil_pkg::OKAY);
        // bad strobes, nothing may change
        add_row("text strb0", OP_WRITE, 32'hc000_0010, 32'h5a5a_5a5a, 4'h0, '0, axil_pkg::SLVERR);
        add_row("text strb3", OP_WRITE, 32'hc000_0010, 32'h5a5a_5a5a, 4'h3, '0, axil_pkg::SLVERR);
        add_row("text strbf", OP_WRITE, 32'hc000_0010, 32'h5a5a_5a5a, 4'hf, '0, axil_pkg::SLVERR);
        add_row("text keep16", OP_TEXT, 32'd16, '0, '0, 32'h41, axil_pkg::OKAY);
        add_row("text keep17", OP_TEXT, 32'd17, '0, '0, 32'h42, axil_pkg::OKAY);
        add_row("text keep18", OP_TEXT, 32'd18, '0, '0, 32'h43, axil_pkg::OKAY);
        add_row("text keep19", OP_TEXT, 32'd19, '0, '0, 32'h44, axil_pkg::OKAY);
        // old main memory and the zero regions
        add_row("main wr", OP_WRITE, 32'h1000_0000, 32'h1234_5678, 4'hf, '0, axil_pkg::DECERR);
        add_row("main rd lo", OP_READ, 32'h0000_0040, '0, '0, '0, axil_pkg::DECERR);
        add_row("main rd hi", OP_READ, 32'hb000_0000, '0, '0, '0, axil_pkg::DECERR);
        add_row("timer wr", OP_WRITE, 32'hd000_0000, 32'hffff_ffff, 4'hf, '0, axil_pkg::OKAY);
        add_row("timer rd", OP_READ, 32'hd000_0000, '0, '0, 32'h0, axil_pkg::OKAY);
        add_row("kbd rd", OP_READ, 32'he000_0004, '0, '0, 32'h0, axil_pkg::OKAY);
    endtask

    task automatic apply_row(input row_t row);
        axil_pkg::resp_e resp;
        axil_pkg::data_t rdata;
        axil_pkg::data_t exp;
        int              word;
        int              lane;
        word = int'((row.addr >> 2) % LOADER_WORDS);
        case (row.op)
            OP_WRITE: begin
                write_word(row.addr, row.data, row.strb, resp);
                compare_value({row.name, " bresp"}, 32'(row.exp_resp), 32'(resp));
                if (row.addr[31:28] == mem_map_pkg::REG_LOADER) begin
                    for (int b = 0; b < 4; b++) begin
                        if (row.strb[b]) begin
                            ld_model[word][8*b +: 8] = row.data[8*b +: 8];
                        end
                    end
                end
                // a lone strobe bit queues one character
                if (row.addr[31:28] == mem_map_pkg::REG_TEXT && $onehot(row.strb)) begin
                    lane = lane_of(row.strb);
                    poll_char({row.name, " char"}, text_index(row.addr, lane),
                              row.data[8*lane +: 8]);
                end
            end
            OP_READ: begin
                read_word(row.addr, rdata, resp);
                compare_value({row.name, " rresp"}, 32'(row.exp_resp), 32'(resp));
                if (row.exp_resp == axil_pkg::OKAY) begin
                    exp = (row.addr[31:28] == mem_map_pkg::REG_LOADER) ? ld_model[word]
                                                                       : row.exp_data;
                    compare_value({row.name, " rdata"}, exp, rdata);
                end
            end
            OP_TEXT: begin
                poll_char(row.name, int'(row.addr), row.exp_data[7:0]);
            end
            default: begin
                fetch_instr(row.name, int'(row.addr));
            end
        endcase
    endtask

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////

    initial begin
        axil_pkg::resp_e    resp;
        axil_pkg::addr_t    baddr;
        axil_pkg::data_t    rnd;
        mem_map_pkg::char_t ch;
        int                 blane;
        int                 idx;
        int                 burst_idx [$];
        axil_req   = '0;
        char_addr  = '0;
        instr_addr = '0;
        reset      = 1'b1;
        for (int w = 0; w < LOADER_WORDS; w++) begin
            ld_model[w] = '0;
        end
        build_table();
        repeat (2) @(posedge text_mem_clk);
        #1;
        reset = 1'b0;

        foreach (rows[r]) begin
            apply_row(rows[r]);
        end

        // random text burst, checked once all are queued
        for (int n = 0; n < BURST_LEN; n++) begin
            baddr = 32'hc000_0000 | (xorshift() & 32'h0fff_fffc);
            rnd   = xorshift();
            blane = int'(rnd & 32'h3);
            ch    = rnd[15:8];
            write_word(baddr, 32'(ch) << (8 * blane), axil_pkg::strb_t'(1 << blane), resp);
            compare_value($sformatf("burst %0d bresp", n), 32'(axil_pkg::OKAY), 32'(resp));
            idx = text_index(baddr, blane);
            text_model[idx] = ch;
            burst_idx.push_back(idx);
        end
        // later writes to a repeated address win
        foreach (burst_idx[i]) begin
            poll_char($sformatf("burst char %0d", i), burst_idx[i], text_model[burst_idx[i]]);
        end

        $display("** PASS **");
        $finish;
    end

endmodule

//--- project.f
hdl/axil_pkg.sv
hdl/mem_map_pkg.sv
hdl/axil_data_port.sv
hdl/text_write_fifo.sv
hdl/text_mem.sv
hdl/loader_mem.sv
hdl/cpu_mem_interface.sv
sim/tb_cpu_mem_interface.sv

//--- run_sim.sh
#!/bin/sh
# build and run the testbench, exit status is the simulation result
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    --timescale 1ns/1ps \
    --top-module tb_cpu_mem_interface \
    -Mdir obj_dir \
    -f project.f

./obj_dir/Vtb_cpu_mem_interface
